// File: Makefile
# Verilator flow for the socTop chip shell

TOP = socTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f socTop.f

sim:
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -f socTop.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then \
		echo "simulation reported failures"; \
		exit 1; \
	fi
	@grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// File: logic/ahbIf.sv
`timescale 1ns/1ps

// internal AHB-lite bus, one manager and the uncore as sole subordinate
interface ahbIf;

  logic [ahbPkg::addrBits-1:0] haddr;
  logic                        hwrite;
  ahbPkg::htransT              htrans;
  ahbPkg::hsizeT               hsize;
  logic [ahbPkg::dataBits-1:0] hwdata;  // data phase
  logic [ahbPkg::dataBits-1:0] hrdata;  // data phase
  logic                        hready;  // muxed ready, seen by both sides
  logic                        hresp;   // 1 = error

  modport manager (
    output haddr, hwrite, htrans, hsize, hwdata,
    input  hrdata, hready, hresp
  );

  modport subordinate (
    input  haddr, hwrite, htrans, hsize, hwdata,
    output hrdata, hready, hresp
  );

endinterface

// File: logic/ahbPkg.sv
// AHB-lite transfer encodings shared by manager and subordinate side
package ahbPkg;

  localparam int dataBits = 32;  // hwdata / hrdata width
  localparam int addrBits = 16;  // haddr width

  // transfer kind on htrans
  typedef enum logic [1:0] {
    htransIdle   = 2'b00,  // no transfer
    htransBusy   = 2'b01,  // never issued here
    htransNonseq = 2'b10,  // single transfer, first beat
    htransSeq    = 2'b11   // bursts not supported
  } htransT;

  // transfer size on hsize
  typedef enum logic [2:0] {
    hsizeByte  = 3'b000,
    hsizeHalf  = 3'b001,
    hsizeWord  = 3'b010,  // only size the debug master issues
    hsizeDword = 3'b011
  } hsizeT;

endpackage

// File: logic/busMaster.sv
`timescale 1ns/1ps

// one sba command becomes one AHB-lite single word transfer
module busMaster (
  input  logic   clk,
  input  logic   rstN,
  sbaIf.master   sba,
  ahbIf.manager  bus
);

  typedef enum logic [1:0] {
    idleS,  // waiting for req
    addrS,  // address phase on the bus
    dataS   // data phase, stretched by hready low
  } stateT;

  stateT                       state;
  stateT                       stateNext;
  logic [ahbPkg::addrBits-1:0] addrQ;
  logic                        writeQ;
  logic [ahbPkg::dataBits-1:0] wdataQ;

  // sequencer
  always_comb begin
    stateNext = state;
    case (state)
      idleS:   if (sba.req) stateNext = addrS;
      addrS:   if (bus.hready) stateNext = dataS;  // prior data phase done
      dataS:   if (bus.hready) stateNext = idleS;
      default: stateNext = idleS;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) state <= idleS;
    else state <= stateNext;
  end

  // command capture, kept until the next req
  always_ff @(posedge clk) begin
    if (state == idleS && sba.req) begin
      addrQ  <= sba.addr;
      writeQ <= sba.write;
      wdataQ <= sba.wdata;
    end
  end

  ////////////////////////////////////////
  // bus drive
  ////////////////////////////////////////
  assign bus.htrans = (state == addrS) ? ahbPkg::htransNonseq : ahbPkg::htransIdle;
  assign bus.hsize  = ahbPkg::hsizeWord;
  assign bus.haddr  = addrQ;   // steady across stalls
  assign bus.hwrite = writeQ;
  assign bus.hwdata = wdataQ;  // valid through data phase

  // result back to the transport
  assign sba.done  = (state == dataS) & bus.hready;
  assign sba.rdata = bus.hrdata;
  assign sba.err   = bus.hresp;

endmodule

// File: logic/clint.sv
`timescale 1ns/1ps

// machine timer, counts the system clock
module clint (
  input  logic        clk,
  input  logic        rstN,
  input  logic        wrEn,
  input  logic [3:0]  regOff,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic        mTimerInt
);

  logic [63:0] mtime;
  logic [63:0] mtimecmp;

  // free running counter, halves writable
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mtime <= '0;
    end else if (wrEn && regOff == socMapPkg::mtimeLo) begin
      mtime <= {mtime[63:32], wdata};
    end else if (wrEn && regOff == socMapPkg::mtimeHi) begin
      mtime <= {wdata, mtime[31:0]};
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // compare value, all ones keeps the interrupt off
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mtimecmp <= '1;
    end else if (wrEn) begin
      if (regOff == socMapPkg::mtimecmpLo) mtimecmp[31:0] <= wdata;
      if (regOff == socMapPkg::mtimecmpHi) mtimecmp[63:32] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) mTimerInt <= 1'b0;
    else mTimerInt <= mtime >= mtimecmp;  // one cycle behind the compare
  end

  // read mux
  always_comb begin
    case (regOff)
      socMapPkg::mtimeLo:    rdata = mtime[31:0];
      socMapPkg::mtimeHi:    rdata = mtime[63:32];
      socMapPkg::mtimecmpLo: rdata = mtimecmp[31:0];
      socMapPkg::mtimecmpHi: rdata = mtimecmp[63:32];
      default:               rdata = '0;
    endcase
  end

endmodule

// File: logic/debugTransport.sv
`timescale 1ns/1ps

// four pin serial port, frames commands and returns responses
module debugTransport (
  input  logic    clk,
  input  logic    rstN,
  input  logic    tck,
  input  logic    tms,
  input  logic    tdi,
  output logic    tdo,
  sbaIf.requester sba
);

  localparam int cntBits = $clog2(socMapPkg::cmdBits + 2);
  localparam logic [cntBits-1:0] cntFull = cntBits'(socMapPkg::cmdBits);
  localparam logic [cntBits-1:0] cntOver = cntBits'(socMapPkg::cmdBits + 1);  // sticky bad

  logic [1:0]                      tckSync;
  logic [1:0]                      tmsSync;
  logic [1:0]                      tdiSync;
  logic                            tckLast;   // edge detect
  logic                            tckRise;
  logic                            shiftEn;   // rising tck with tms high
  logic                            frameOk;
  logic                            busy;      // command in flight
  logic [cntBits-1:0]              bitCnt;
  logic [socMapPkg::cmdBits-1:0]   cmdShift;
  logic [socMapPkg::rspBits-1:0]   rspShift;

  ////////////////////////////////////////
  // pin synchronizers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      tckSync <= '0;
      tmsSync <= '0;
      tdiSync <= '0;
      tckLast <= 1'b0;
    end else begin
      tckSync <= {tckSync[0], tck};
      tmsSync <= {tmsSync[0], tms};
      tdiSync <= {tdiSync[0], tdi};
      tckLast <= tckSync[1];
    end
  end

  assign tckRise = tckSync[1] & ~tckLast;
  assign shiftEn = tckRise & tmsSync[1];
  assign frameOk = tckRise & ~tmsSync[1] & (bitCnt == cntFull);  // exact length only

  ////////////////////////////////////////
  // framing and request
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      bitCnt  <= '0;
      busy    <= 1'b0;
      sba.req <= 1'b0;
    end else begin
      sba.req <= frameOk;  // lands one clk after the closing edge
      if (frameOk) busy <= 1'b1;
      else if (sba.done) busy <= 1'b0;
      if (tckRise) begin
        if (!tmsSync[1]) bitCnt <= '0;  // frame end, good or not
        else if (busy) bitCnt <= cntOver;  // bits during a pending cmd poison the frame
        else if (bitCnt != cntOver) bitCnt <= bitCnt + 1'b1;
      end
    end
  end

  // command bits, frozen while busy so addr/wdata hold
  always_ff @(posedge clk) begin
    if (shiftEn && !busy) cmdShift <= {tdiSync[1], cmdShift[socMapPkg::cmdBits-1:1]};
  end

  assign sba.write = cmdShift[0];
  assign sba.addr  = cmdShift[ahbPkg::addrBits:1];
  assign sba.wdata = cmdShift[socMapPkg::cmdBits-1:ahbPkg::addrBits+1];

  // response capture and shift out
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) rspShift <= '0;
    else if (sba.done) rspShift <= {sba.rdata, sba.err};  // err goes out first
    else if (shiftEn) rspShift <= {1'b0, rspShift[socMapPkg::rspBits-1:1]};
  end

  assign tdo = rspShift[0];

endmodule

// File: logic/gpio.sv
`timescale 1ns/1ps

// output, enable and synchronized input registers
module gpio #(
  parameter int GpioWidth = 32
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 wrEn,
  input  logic [3:0]           regOff,
  input  logic [31:0]          wdata,
  output logic [31:0]          rdata,
  input  logic [GpioWidth-1:0] gpioIn,
  output logic [GpioWidth-1:0] gpioOut,
  output logic [GpioWidth-1:0] gpioEn
);

  logic [GpioWidth-1:0] inMeta;  // first sync stage
  logic [GpioWidth-1:0] inSync;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      gpioOut <= '0;
      gpioEn  <= '0;  // pins start as inputs
      inMeta  <= '0;
      inSync  <= '0;
    end else begin
      inMeta <= gpioIn;
      inSync <= inMeta;
      if (wrEn && regOff == socMapPkg::gpioOutOff) gpioOut <= wdata[GpioWidth-1:0];
      if (wrEn && regOff == socMapPkg::gpioEnOff) gpioEn <= wdata[GpioWidth-1:0];
    end
  end

  // upper bits read zero
  always_comb begin
    rdata = '0;
    case (regOff)
      socMapPkg::gpioOutOff: rdata[GpioWidth-1:0] = gpioOut;
      socMapPkg::gpioEnOff:  rdata[GpioWidth-1:0] = gpioEn;
      socMapPkg::gpioInOff:  rdata[GpioWidth-1:0] = inSync;
      default:               rdata = '0;
    endcase
  end

endmodule

// File: logic/sbaIf.sv
`timescale 1ns/1ps

// system bus access request from debug transport to bus master
interface sbaIf;

  logic                          req;    // one cycle pulse
  logic                          write;  // held until done
  logic [ahbPkg::addrBits-1:0]   addr;
  logic [ahbPkg::dataBits-1:0]   wdata;
  logic [ahbPkg::dataBits-1:0]   rdata;  // valid with done
  logic                          err;
  logic                          done;   // one cycle pulse

  modport requester (output req, write, addr, wdata, input rdata, err, done);
  modport master (input req, write, addr, wdata, output rdata, err, done);

endinterface

// File: logic/socMapPkg.sv
// memory map of the uncore and debug frame format
package socMapPkg;

  ////////////////////////////////////////
  // region bases
  ////////////////////////////////////////
  localparam logic [ahbPkg::addrBits-1:0] clintBase = 16'h0000;  // 4 KiB
  localparam logic [ahbPkg::addrBits-1:0] gpioBase  = 16'h1000;  // 4 KiB
  localparam logic [ahbPkg::addrBits-1:0] extBase   = 16'h8000;  // 32 KiB to top
  localparam int periphBits = 12;  // log2 of a 4 KiB peripheral region

  // clint register offsets
  localparam logic [3:0] mtimeLo    = 4'h0;
  localparam logic [3:0] mtimeHi    = 4'h4;
  localparam logic [3:0] mtimecmpLo = 4'h8;
  localparam logic [3:0] mtimecmpHi = 4'hC;

  // gpio register offsets
  localparam logic [3:0] gpioOutOff = 4'h0;
  localparam logic [3:0] gpioEnOff  = 4'h4;
  localparam logic [3:0] gpioInOff  = 4'h8;

  // serial frames, lsb first
  localparam int cmdBits = 49;  // write, addr[15:0], data[31:0]
  localparam int rspBits = 33;  // err, rdata[31:0]

endpackage

// File: logic/socTop.sv
`timescale 1ns/1ps

// chip top, debug port masters the uncore and the external bus
module socTop #(
  parameter int GpioWidth = 32
) (
  input  logic                        clk,
  input  logic                        rstN,       // async, from the pin
  // serial test port
  input  logic                        tck,
  input  logic                        tms,
  input  logic                        tdi,
  output logic                        tdo,
  // external AHB-lite region
  output logic                        hResetN,
  output logic [ahbPkg::addrBits-1:0] hAddr,
  output logic [ahbPkg::dataBits-1:0] hWdata,
  output logic                        hWrite,
  output logic [1:0]                  hTrans,
  output logic [2:0]                  hSize,
  output logic                        hReady,
  output logic                        hSelExt,
  input  logic [ahbPkg::dataBits-1:0] hRdataExt,
  input  logic                        hReadyExt,
  input  logic                        hRespExt,
  // pins
  input  logic [GpioWidth-1:0]        gpioIn,
  output logic [GpioWidth-1:0]        gpioOut,
  output logic [GpioWidth-1:0]        gpioEn,
  output logic                        mTimerInt
);

  logic [1:0] rstSync;  // release synchronizer
  logic       sysRstN;

  sbaIf sba ();
  ahbIf bus ();

  ////////////////////////////////////////
  // reset, assert async, release after 2 edges
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) rstSync <= '0;
    else rstSync <= {rstSync[0], 1'b1};
  end

  assign sysRstN = rstSync[1];
  assign hResetN = sysRstN;

  // bus toward external memory
  assign hAddr  = bus.haddr;
  assign hWdata = bus.hwdata;
  assign hWrite = bus.hwrite;
  assign hTrans = bus.htrans;
  assign hSize  = bus.hsize;
  assign hReady = bus.hready;

  debugTransport debugTransport_i (.clk, .rstN(sysRstN), .tck, .tms, .tdi, .tdo, .sba);

  busMaster busMaster_i (.clk, .rstN(sysRstN), .sba, .bus);

  uncore #(.GpioWidth(GpioWidth)) uncore_i (
    .clk, .rstN(sysRstN), .bus, .hSelExt, .hRdataExt, .hReadyExt, .hRespExt,
    .gpioIn, .gpioOut, .gpioEn, .mTimerInt
  );

endmodule

// File: logic/uncore.sv
`timescale 1ns/1ps

// address decode and response mux for clint, gpio and the external region
module uncore #(
  parameter int GpioWidth = 32
) (
  input  logic                 clk,
  input  logic                 rstN,
  ahbIf.subordinate            bus,
  output logic                 hSelExt,
  input  logic [31:0]          hRdataExt,
  input  logic                 hReadyExt,
  input  logic                 hRespExt,
  input  logic [GpioWidth-1:0] gpioIn,
  output logic [GpioWidth-1:0] gpioOut,
  output logic [GpioWidth-1:0] gpioEn,
  output logic                 mTimerInt
);

  localparam int hiBits = ahbPkg::addrBits - socMapPkg::periphBits;

  logic [hiBits-1:0] regionTag;  // upper address bits
  logic              addrPhase;
  logic              selClint;
  logic              selGpio;
  logic              selExt;
  logic              dpClint;    // data phase owner flags
  logic              dpGpio;
  logic              dpExt;
  logic              dpErr;
  logic              errSecond;  // second cycle of error response
  logic              dpWrite;
  logic [3:0]        dpOff;
  logic [31:0]       clintRdata;
  logic [31:0]       gpioRdata;

  ////////////////////////////////////////
  // address phase decode
  ////////////////////////////////////////
  assign regionTag = bus.haddr[ahbPkg::addrBits-1:socMapPkg::periphBits];
  assign addrPhase = (bus.htrans == ahbPkg::htransNonseq) & bus.hready;
  assign selClint  = regionTag == socMapPkg::clintBase[ahbPkg::addrBits-1:socMapPkg::periphBits];
  assign selGpio   = regionTag == socMapPkg::gpioBase[ahbPkg::addrBits-1:socMapPkg::periphBits];
  assign selExt    = bus.haddr >= socMapPkg::extBase;

  // flags move on only when the current data phase finishes
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dpClint   <= 1'b0;
      dpGpio    <= 1'b0;
      dpExt     <= 1'b0;
      dpErr     <= 1'b0;
      errSecond <= 1'b0;
    end else begin
      errSecond <= dpErr & ~errSecond;
      if (bus.hready) begin
        dpClint <= addrPhase & selClint;
        dpGpio  <= addrPhase & selGpio;
        dpExt   <= addrPhase & selExt;
        dpErr   <= addrPhase & ~(selClint | selGpio | selExt);  // hole in the map
      end
    end
  end

  always_ff @(posedge clk) begin
    if (addrPhase) begin
      dpWrite <= bus.hwrite;
      dpOff   <= bus.haddr[3:0];
    end
  end

  ////////////////////////////////////////
  // data phase response
  ////////////////////////////////////////
  assign hSelExt = ((bus.htrans == ahbPkg::htransNonseq) & selExt) | dpExt;

  always_comb begin
    bus.hready = 1'b1;  // internal regions never wait
    bus.hresp  = 1'b0;
    bus.hrdata = '0;
    if (dpExt) begin
      bus.hready = hReadyExt;
      bus.hresp  = hRespExt;
      bus.hrdata = hRdataExt;
    end else if (dpErr) begin
      bus.hready = errSecond;  // low then high
      bus.hresp  = 1'b1;
    end else if (dpClint) begin
      bus.hrdata = clintRdata;
    end else if (dpGpio) begin
      bus.hrdata = gpioRdata;
    end
  end

  clint clint_i (
    .clk, .rstN, .wrEn(dpClint & dpWrite), .regOff(dpOff), .wdata(bus.hwdata),
    .rdata(clintRdata), .mTimerInt
  );

  gpio #(.GpioWidth(GpioWidth)) gpio_i (
    .clk, .rstN, .wrEn(dpGpio & dpWrite), .regOff(dpOff), .wdata(bus.hwdata),
    .rdata(gpioRdata), .gpioIn, .gpioOut, .gpioEn
  );

endmodule

// File: socTop.f
logic/ahbPkg.sv
logic/socMapPkg.sv
logic/sbaIf.sv
logic/ahbIf.sv
logic/debugTransport.sv
logic/busMaster.sv
logic/clint.sv
logic/gpio.sv
logic/uncore.sv
logic/socTop.sv
test/socTop_props.sv
test/socTb.sv

// File: test/socTb.sv
`timescale 1ns/1ps

// chip level testbench, serial debug port in, external AHB memory model out
module socTb;

  localparam int cycleLimit = 40000;  // ~30 commands at ~900 cycles each, plus margin
  localparam int period     = 100;

  logic        clk;
  logic        rstN;
  logic        tck;
  logic        tms;
  logic        tdi;
  logic        tdo;
  logic        hResetN;
  logic [15:0] hAddr;
  logic [31:0] hWdata;
  logic        hWrite;
  logic [1:0]  hTrans;
  logic [2:0]  hSize;
  logic        hReady;
  logic        hSelExt;
  logic [31:0] hRdataExt = '0;    // driven by the memory model
  logic        hReadyExt = 1'b1;
  logic        hRespExt  = 1'b0;
  logic [31:0] gpioIn;
  logic [31:0] gpioOut;
  logic [31:0] gpioEn;
  logic        mTimerInt;

  int          errCount   = 0;
  int          cycleCount = 0;
  int          xferCount  = 0;   // accepted nonseq address phases
  int          selCount   = 0;   // cycles with hSelExt high
  logic [31:0] lfsr       = 32'h5f59bd4f;
  logic [31:0] expMem [0:1023];  // expected external contents
  logic [31:0] extMem [0:1023];  // memory model contents
  logic        extValid [0:1023] = '{default: 1'b0};
  logic        extBusy  = 1'b0;  // model is in a data phase
  logic        extWr    = 1'b0;
  logic [9:0]  extIdx   = '0;
  logic        extErr   = 1'b0;  // next access answers with an error
  logic [1:0]  stallCycles = '0; // wait states for the next access
  int          waitLeft = 0;

  socTop #(.GpioWidth(32)) socTop_i (
    .clk, .rstN, .tck, .tms, .tdi, .tdo, .hResetN, .hAddr, .hWdata, .hWrite, .hTrans,
    .hSize, .hReady, .hSelExt, .hRdataExt, .hReadyExt, .hRespExt, .gpioIn, .gpioOut,
    .gpioEn, .mTimerInt
  );

  bind socTop socTopProps props_i (
    .clk, .hResetN, .hAddr, .hWdata, .hWrite, .hTrans, .hSize, .hReady, .hSelExt
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycleCount);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // bus activity counters
  always @(posedge clk) begin
    if (hTrans == 2'b10 && hReady) xferCount++;
    if (hSelExt) selCount++;
  end

  ////////////////////////////////////////
  // external memory model
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (extBusy && hReady) begin  // data phase ends here
      if (extWr) begin
        extMem[extIdx]   = hWdata;
        extValid[extIdx] = 1'b1;
      end
      extBusy = 1'b0;
    end
    if (hSelExt && hTrans == 2'b10 && hReady) begin
      extBusy  = 1'b1;
      extWr    = hWrite;
      extIdx   = hAddr[11:2];
      waitLeft = extErr ? 1 : int'(stallCycles);  // error needs one low cycle
    end
    #10;
    if (extBusy && waitLeft > 0) begin
      hReadyExt = 1'b0;
      waitLeft--;
    end else begin
      hReadyExt = 1'b1;
    end
    hRespExt  = extBusy & extErr;
    hRdataExt = extValid[extIdx] ? extMem[extIdx] : fillWord({4'h8, extIdx, 2'b00});
  end

  // fill pattern, unique per address
  function automatic logic [31:0] fillWord(input logic [15:0] addr);
    return {~addr, addr};
  endfunction

  // galois lfsr, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic nextCycles(input int n);
    repeat (n) @(posedge clk);
    #10;  // drive point
  endtask

  task automatic checkVal(input string name, input logic [31:0] expVal,
                          input logic [31:0] actVal);
    assert (actVal === expVal)
    else begin
      errCount++;
      $display("ERR %s expected %h actual %h", name, expVal, actVal);
    end
  endtask

  // one tck period, 8 clk long
  task automatic tckBit(input logic tmsVal, input logic tdiVal);
    tck = 1'b0;
    tms = tmsVal;
    tdi = tdiVal;
    nextCycles(4);
    tck = 1'b1;
    nextCycles(4);
  endtask

  // shift a frame, close it, then read back err and rdata through tdo
  task automatic runCmd(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                        input int nBits, output logic err, output logic [31:0] rdata);
    logic [48:0] frame;
    frame = {wdata, addr, wr};  // lsb goes first
    err   = 1'b0;
    rdata = '0;
    for (int i = 0; i < nBits; i++) tckBit(1'b1, frame[i]);
    tck = 1'b0;
    tms = 1'b0;
    nextCycles(4);
    tck = 1'b1;  // closing edge
    if (nBits != socMapPkg::cmdBits) begin
      nextCycles(24);
    end else begin
      @(negedge clk);
      while (socTop_i.sba.done !== 1'b1) @(negedge clk);
      nextCycles(2);
      err = tdo;
      for (int i = 0; i < 32; i++) begin
        tckBit(1'b1, 1'b0);
        rdata[i] = tdo;
      end
      tckBit(1'b0, 1'b0);  // clears the bit count
    end
  endtask

  task automatic busWrite(input string name, input logic [15:0] addr, input logic [31:0] data);
    logic        err;
    logic [31:0] rdata;
    runCmd(1'b1, addr, data, socMapPkg::cmdBits, err, rdata);
    checkVal({name, "Err"}, 32'd0, {31'd0, err});
  endtask

  task automatic busRead(input logic [15:0] addr, output logic err, output logic [31:0] rdata);
    runCmd(1'b0, addr, 32'd0, socMapPkg::cmdBits, err, rdata);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial begin
    logic        err;
    logic [31:0] rd;
    logic [31:0] t1;
    logic [31:0] t2;
    logic [31:0] data;
    logic [9:0]  idx;
    int          selBefore;
    int          xferBefore;
    int          waitCnt;

    rstN   = 1'b0;
    tck    = 1'b0;
    tms    = 1'b0;
    tdi    = 1'b0;
    gpioIn = '0;
    for (int i = 0; i < 1024; i++) expMem[i] = fillWord({4'h8, 10'(i), 2'b00});
    repeat (10) @(posedge clk);
    #10;
    checkVal("resetHold", 32'd0, {31'd0, hResetN});
    rstN = 1'b1;
    nextCycles(4);
    checkVal("resetRelease", 32'd1, {31'd0, hResetN});
    checkVal("resetGpioEn", 32'd0, gpioEn);
    checkVal("resetIrq", 32'd0, {31'd0, mTimerInt});
    checkVal("resetTrans", 32'd0, {30'd0, hTrans});
    checkVal("busSize", {29'd0, 3'b010}, {29'd0, hSize});  // word transfers only

    // gpio registers and pins
    gpioIn = 32'h1234_5678;
    busWrite("gpioOutWr", socMapPkg::gpioBase + 16'(socMapPkg::gpioOutOff), 32'ha5a5_0f0f);
    checkVal("gpioOutPin", 32'ha5a5_0f0f, gpioOut);
    busWrite("gpioEnWr", socMapPkg::gpioBase + 16'(socMapPkg::gpioEnOff), 32'h0000_ffff);
    checkVal("gpioEnPin", 32'h0000_ffff, gpioEn);
    busRead(socMapPkg::gpioBase + 16'(socMapPkg::gpioInOff), err, rd);
    checkVal("gpioInErr", 32'd0, {31'd0, err});
    checkVal("gpioInRd", 32'h1234_5678, rd);

    // second reset pulse mid run
    rstN = 1'b0;
    nextCycles(3);
    checkVal("midResetOut", 32'd0, gpioOut);
    checkVal("midResetEn", 32'd0, gpioEn);
    rstN = 1'b1;
    nextCycles(4);

    // timer count and interrupt
    busRead(socMapPkg::clintBase + 16'(socMapPkg::mtimeLo), err, t1);
    busRead(socMapPkg::clintBase + 16'(socMapPkg::mtimeLo), err, t2);
    assert (t2 > t1)
    else begin
      errCount++;
      $display("ERR timerCount expected above %h actual %h", t1, t2);
    end
    busWrite("cmpLoWr", socMapPkg::clintBase + 16'(socMapPkg::mtimecmpLo), t2 + 32'd4000);
    busWrite("cmpHiWr", socMapPkg::clintBase + 16'(socMapPkg::mtimecmpHi), 32'd0);
    checkVal("timerIrqEarly", 32'd0, {31'd0, mTimerInt});
    waitCnt = 0;
    while (mTimerInt !== 1'b1 && waitCnt < 6000) begin
      nextCycles(1);
      waitCnt++;
    end
    checkVal("timerIrqSet", 32'd1, {31'd0, mTimerInt});
    busWrite("cmpHiOff", socMapPkg::clintBase + 16'(socMapPkg::mtimecmpHi), 32'hffff_ffff);
    checkVal("timerIrqClear", 32'd0, {31'd0, mTimerInt});

    // external region, write then read back with random stalls
    for (int n = 0; n < 8; n++) begin
      idx  = 10'(randBits(10));
      data = randBits(32);
      if (n < 6) begin
        stallCycles = 2'(randBits(2));
        selBefore   = selCount;
        busWrite("extWr", {4'h8, idx, 2'b00}, data);
        expMem[idx] = data;
        checkVal("extWrSel", 32'd1, {31'd0, selCount > selBefore});
      end
      stallCycles = 2'(randBits(2));
      selBefore   = selCount;
      busRead({4'h8, idx, 2'b00}, err, rd);
      checkVal("extRdErr", 32'd0, {31'd0, err});
      checkVal("extRd", expMem[idx], rd);
      checkVal("extRdSel", 32'd1, {31'd0, selCount > selBefore});
    end

    // error paths
    busRead(16'h4000, err, rd);
    checkVal("unmappedErr", 32'd1, {31'd0, err});
    extErr = 1'b1;
    busRead(16'h8010, err, rd);
    checkVal("extRespErr", 32'd1, {31'd0, err});
    extErr     = 1'b0;
    xferBefore = xferCount;
    runCmd(1'b1, socMapPkg::gpioBase, 32'hdead_beef, socMapPkg::cmdBits - 1, err, rd);
    checkVal("shortFrameXfer", 32'(xferBefore), 32'(xferCount));
    checkVal("shortFrameGpio", 32'd0, gpioOut);
    busRead(socMapPkg::gpioBase + 16'(socMapPkg::gpioInOff), err, rd);  // port recovered
    checkVal("recoverRd", 32'h1234_5678, rd);

    nextCycles(10);
    $display("errors: %0d from checks, %0d from assertions", errCount,
             socTop_i.props_i.propFails);
    if (errCount == 0 && socTop_i.props_i.propFails == 0) $display("ALL CHECKS PASSED");
    else $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: test/socTop_props.sv
`timescale 1ns/1ps

// reset and AHB-lite rules on the chip pins, bound into socTop
module socTopProps (
  input logic                        clk,
  input logic                        hResetN,
  input logic [ahbPkg::addrBits-1:0] hAddr,
  input logic [ahbPkg::dataBits-1:0] hWdata,
  input logic                        hWrite,
  input logic [1:0]                  hTrans,
  input logic [2:0]                  hSize,
  input logic                        hReady,
  input logic                        hSelExt
);

  int propFails = 0;  // failure tally

  ////////////////////////////////////////
  // reset
  ////////////////////////////////////////
  idleInReset: assert property (@(posedge clk) !hResetN |-> hTrans == ahbPkg::htransIdle)
    else begin
      propFails++;
      $error("a transfer was issued while the bus reset was active");
    end

  // select only inside the external window
  selInRange: assert property (
    @(posedge clk) disable iff (!hResetN)
    hSelExt |-> hAddr >= socMapPkg::extBase
  ) else begin
    propFails++;
    $error("hSelExt was high for address %h below the external region", hAddr);
  end

  ////////////////////////////////////////
  // stall rule
  ////////////////////////////////////////
  holdDuringStall: assert property (
    @(posedge clk) disable iff (!hResetN)
    !hReady |=> $stable(hAddr) && $stable(hWrite) && $stable(hWdata)
                && $stable(hTrans) && $stable(hSize)
  ) else begin
    propFails++;
    $error("bus signals changed while hReady was low");
  end

endmodule
